// File: design/laser_cfg_pkg.sv
package laser_cfg_pkg;

    //////////////////////////////
    // Laser driver channels
    //////////////////////////////

    localparam int n_laser_ch = 3;

    // One enable bit per driver channel
    typedef logic [n_laser_ch-1:0] laser_mask_t;

    //////////////////////////////
    // Shot timing
    //////////////////////////////

    localparam int period_w = 32;

    // Shot period in clk200 cycles
    typedef logic [period_w-1:0] pulse_period_t;

    // Full settings set, mask in the upper bits
    typedef struct packed {
        laser_mask_t   mask;
        pulse_period_t period;
    } pulse_cfg_t;

endpackage

// File: design/adc_data_pkg.sv
package adc_data_pkg;

    //////////////////////////////
    // Converter samples
    //////////////////////////////

    localparam int adc_width        = 14;
    localparam int samples_per_word = 4;

    // Unsigned offset code
    typedef logic [adc_width-1:0] adc_sample_t;

    // What the converter delivers each cycle
    typedef struct packed {
        adc_sample_t sample;
        logic        ovf;
    } adc_in_t;

    //////////////////////////////
    // Packed capture words
    //////////////////////////////

    // Earliest sample in the lowest bits
    typedef logic [adc_width*samples_per_word-1:0] merge_word_t;

    // ovf is the OR over the four samples
    typedef struct packed {
        merge_word_t data;
        logic        ovf;
    } cap_word_t;

endpackage

// File: design/laser_pulse_gen.sv
`timescale 1ns/1ps

module laser_pulse_gen #(
    parameter int PULSE_CYCLES = 4
) (
    input  logic                       clk200,
    input  logic                       arst_n,
    input  logic                       cap_mode,
    input  laser_cfg_pkg::pulse_cfg_t  cap_cfg,
    input  laser_cfg_pkg::pulse_cfg_t  com_cfg,
    input  logic                       com_open,
    input  logic                       com_close,
    output laser_cfg_pkg::laser_mask_t ldd_wp,
    output laser_cfg_pkg::laser_mask_t ldd_wn,
    output logic                       cap_trig
);
    import laser_cfg_pkg::*;

    localparam int pw_w = $clog2(PULSE_CYCLES + 1);

    pulse_cfg_t      sel_cfg;
    laser_mask_t     mask_q;
    pulse_period_t   period_cnt;
    logic [pw_w-1:0] pw_cnt;
    logic            run;
    logic            start_run;
    logic            shot_start;

    // Mode picks the settings set
    assign sel_cfg    = cap_mode ? cap_cfg : com_cfg;
    assign start_run  = com_open && !com_close && !run;
    assign shot_start = run && !com_close && (period_cnt == '0);

    //////////////////////////////
    // Run level and period
    //////////////////////////////

    // Close wins over open
    always_ff @(posedge clk200 or negedge arst_n) begin
        if (!arst_n) begin
            run <= 1'b0;
        end else if (com_close) begin
            run <= 1'b0;
        end else if (com_open) begin
            run <= 1'b1;
        end
    end

    always_ff @(posedge clk200 or negedge arst_n) begin
        if (!arst_n) begin
            period_cnt <= '0;
        end else if (start_run || shot_start) begin
            period_cnt <= sel_cfg.period - 1'b1;
        end else if (run && (period_cnt != '0)) begin
            period_cnt <= period_cnt - 1'b1;
        end
    end

    // Mask for the coming shot
    always_ff @(posedge clk200) begin
        if (start_run || shot_start) begin
            mask_q <= sel_cfg.mask;
        end
    end

    //////////////////////////////
    // Driver pulse
    //////////////////////////////

    always_ff @(posedge clk200 or negedge arst_n) begin
        if (!arst_n) begin
            ldd_wp   <= '0;
            pw_cnt   <= '0;
            cap_trig <= 1'b0;
        end else begin
            cap_trig <= shot_start;
            if (shot_start) begin
                ldd_wp <= mask_q;
                pw_cnt <= pw_w'(PULSE_CYCLES - 1);
            end else if (pw_cnt != '0) begin
                pw_cnt <= pw_cnt - 1'b1;
            end else begin
                ldd_wp <= '0;
            end
        end
    end

    assign ldd_wn = ~ldd_wp;

    // Next shot must land after the pulse has ended
    a_period_gt_width: assert property (@(posedge clk200) disable iff (!arst_n)
        shot_start |-> (sel_cfg.period > PULSE_CYCLES));

    a_trig_single: assert property (@(posedge clk200) disable iff (!arst_n)
        cap_trig |=> !cap_trig);

endmodule

// File: design/adc_sample_merge.sv
`timescale 1ns/1ps

module adc_sample_merge (
    input  logic                    clk200,
    input  logic                    arst_n,
    input  adc_data_pkg::adc_in_t   adc_in,
    input  logic                    cap_trig,
    output adc_data_pkg::cap_word_t merge_word,
    output logic                    merge_valid
);
    import adc_data_pkg::*;

    localparam int lane_w  = $clog2(samples_per_word);
    localparam int upper_w = adc_width * (samples_per_word - 1);

    adc_in_t           adc_q;
    merge_word_t       asm_q;
    logic [upper_w-1:0] asm_upper;
    logic              ovf_acc;
    logic [lane_w-1:0] lane_cnt;
    logic [lane_w-1:0] lane;
    logic              last_lane;

    // Shot realigns the word boundary
    assign lane      = cap_trig ? '0 : lane_cnt;
    assign last_lane = (lane == lane_w'(samples_per_word - 1));
    assign asm_upper = asm_q[$bits(merge_word_t)-1 -: upper_w];

    //////////////////////////////
    // Sample assembly
    //////////////////////////////

    // New samples enter at the top and move down
    always_ff @(posedge clk200) begin
        adc_q   <= adc_in;
        asm_q   <= {adc_q.sample, asm_upper};
        ovf_acc <= (lane == '0) ? adc_q.ovf : (ovf_acc | adc_q.ovf);
        if (last_lane) begin
            merge_word.data <= {adc_q.sample, asm_upper};
            merge_word.ovf  <= ovf_acc | adc_q.ovf;
        end
    end

    always_ff @(posedge clk200 or negedge arst_n) begin
        if (!arst_n) begin
            lane_cnt    <= '0;
            merge_valid <= 1'b0;
        end else begin
            lane_cnt    <= last_lane ? '0 : lane + 1'b1;
            merge_valid <= last_lane;
        end
    end

endmodule

// File: design/capture_ctrl.sv
`timescale 1ns/1ps

module capture_ctrl #(
    parameter int CAP_WORDS = 8
) (
    input  logic                    clk200,
    input  logic                    arst_n,
    input  logic                    cap_trig,
    input  adc_data_pkg::cap_word_t merge_word,
    input  logic                    merge_valid,
    output adc_data_pkg::cap_word_t cap_data,
    output logic                    cap_valid,
    output logic                    capr_rdy
);

    localparam int cnt_w = $clog2(CAP_WORDS + 1);

    typedef enum logic {
        cap_idle,
        cap_open
    } cap_state_t;

    cap_state_t       state;
    logic [cnt_w-1:0] word_cnt;
    logic             take_word;
    logic             last_word;

    assign take_word = (state == cap_open) && merge_valid;
    assign last_word = (word_cnt == cnt_w'(CAP_WORDS - 1));

    //////////////////////////////
    // Window FSM
    //////////////////////////////

    // Triggers during an open window are dropped
    always_ff @(posedge clk200 or negedge arst_n) begin
        if (!arst_n) begin
            state     <= cap_idle;
            word_cnt  <= '0;
            cap_valid <= 1'b0;
            capr_rdy  <= 1'b0;
        end else begin
            cap_valid <= take_word;
            capr_rdy  <= take_word && last_word;
            case (state)
                cap_idle: begin
                    if (cap_trig) begin
                        state    <= cap_open;
                        word_cnt <= '0;
                    end
                end
                cap_open: begin
                    if (take_word) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (last_word) begin
                            state <= cap_idle;
                        end
                    end
                end
                default: begin
                    state <= cap_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk200) begin
        if (take_word) begin
            cap_data <= merge_word;
        end
    end

endmodule

// File: design/lidar_top.sv
`timescale 1ns/1ps

module lidar_top #(
    parameter int PULSE_CYCLES = 4,
    parameter int CAP_WORDS    = 8
) (
    input  logic                       clk200,
    input  logic                       arst_n,
    input  logic                       cap_mode,
    input  laser_cfg_pkg::pulse_cfg_t  cap_cfg,
    input  laser_cfg_pkg::pulse_cfg_t  com_cfg,
    input  logic                       com_open,
    input  logic                       com_close,
    input  adc_data_pkg::adc_in_t      adc_in,
    output laser_cfg_pkg::laser_mask_t ldd_wp,
    output laser_cfg_pkg::laser_mask_t ldd_wn,
    output logic                       cap_trig,
    output adc_data_pkg::cap_word_t    cap_data,
    output logic                       cap_valid,
    output logic                       capr_rdy
);
    import adc_data_pkg::*;

    cap_word_t merge_word;
    logic      merge_valid;

    laser_pulse_gen #(
        .PULSE_CYCLES (PULSE_CYCLES )
    ) laser_pulse_gen_ins0 (
        .clk200       (clk200       ),
        .arst_n       (arst_n       ),
        .cap_mode     (cap_mode     ),
        .cap_cfg      (cap_cfg      ),
        .com_cfg      (com_cfg      ),
        .com_open     (com_open     ),
        .com_close    (com_close    ),
        .ldd_wp       (ldd_wp       ),
        .ldd_wn       (ldd_wn       ),
        .cap_trig     (cap_trig     )
    );

    // Words align to each shot
    adc_sample_merge adc_sample_merge_ins0 (
        .clk200       (clk200       ),
        .arst_n       (arst_n       ),
        .adc_in       (adc_in       ),
        .cap_trig     (cap_trig     ),
        .merge_word   (merge_word   ),
        .merge_valid  (merge_valid  )
    );

    capture_ctrl #(
        .CAP_WORDS    (CAP_WORDS    )
    ) capture_ctrl_ins0 (
        .clk200       (clk200       ),
        .arst_n       (arst_n       ),
        .cap_trig     (cap_trig     ),
        .merge_word   (merge_word   ),
        .merge_valid  (merge_valid  ),
        .cap_data     (cap_data     ),
        .cap_valid    (cap_valid    ),
        .capr_rdy     (capr_rdy     )
    );

endmodule

// File: test/tb_lidar_top.sv
`timescale 1ns/1ps

module tb_lidar_top;
    import laser_cfg_pkg::*;
    import adc_data_pkg::*;

    localparam int clk_half     = 4;
    localparam int reset_cycles = 3;
    localparam int pulse_cycles = 4;
    localparam int cap_words    = 8;
    localparam int lanes        = 4;
    localparam int sample_w     = 14;
    localparam int hist_depth   = 4096;
    localparam int n_rows       = 5;

    typedef struct packed {
        logic       mode;
        pulse_cfg_t cap;
        pulse_cfg_t com;
        logic [7:0] shots;
        logic       early;
    } row_t;

    // mode, cap_cfg {mask, period}, com_cfg {mask, period}, shots, early close
    row_t tbl [n_rows] = '{
        '{1'b1, '{3'b101, 32'd40}, '{3'b010, 32'd60}, 8'd3, 1'b0},
        '{1'b0, '{3'b101, 32'd40}, '{3'b010, 32'd60}, 8'd2, 1'b1},
        '{1'b1, '{3'b111, 32'd48}, '{3'b001, 32'd44}, 8'd2, 1'b1},
        '{1'b0, '{3'b110, 32'd52}, '{3'b011, 32'd41}, 8'd4, 1'b0},
        '{1'b1, '{3'b100, 32'd36}, '{3'b111, 32'd64}, 8'd1, 1'b0}
    };

    logic        clk200;
    logic        arst_n;
    logic        cap_mode;
    pulse_cfg_t  cap_cfg;
    pulse_cfg_t  com_cfg;
    logic        com_open;
    logic        com_close;
    adc_in_t     adc_in;
    laser_mask_t ldd_wp;
    laser_mask_t ldd_wn;
    logic        cap_trig;
    cap_word_t   cap_data;
    logic        cap_valid;
    logic        capr_rdy;

    int          cyc = 0;
    int          errors = 0;
    int          test_errors = 0;
    logic [31:0] rng = 32'hb39788a8;
    adc_in_t     hist [0:hist_depth-1];

    lidar_top #(
        .PULSE_CYCLES (pulse_cycles),
        .CAP_WORDS    (cap_words   )
    ) i_dut (
        .clk200    (clk200   ),
        .arst_n    (arst_n   ),
        .cap_mode  (cap_mode ),
        .cap_cfg   (cap_cfg  ),
        .com_cfg   (com_cfg  ),
        .com_open  (com_open ),
        .com_close (com_close),
        .adc_in    (adc_in   ),
        .ldd_wp    (ldd_wp   ),
        .ldd_wn    (ldd_wn   ),
        .cap_trig  (cap_trig ),
        .cap_data  (cap_data ),
        .cap_valid (cap_valid),
        .capr_rdy  (capr_rdy )
    );

    initial clk200 = 1'b0;
    always #clk_half clk200 = ~clk200;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Four driven samples from base on, earliest lowest
    function automatic cap_word_t expected_word(input int base);
        cap_word_t w;
        w = '0;
        for (int i = 0; i < lanes; i++) begin
            w.data[i*sample_w +: sample_w] = hist[base+i].sample;
            w.ovf = w.ovf | hist[base+i].ovf;
        end
        return w;
    endfunction

    task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("ERR %s expected %0h got %0h at %0t", name, exp, act, $time);
            errors++;
            test_errors++;
        end
    endtask

    ////////////////////////////////
    // ADC stream, one sample per cycle
    ////////////////////////////////

    always @(posedge clk200) begin
        cyc = cyc + 1;
        #1;
        rng = next_random(rng);
        adc_in.sample = rng[sample_w-1:0];
        adc_in.ovf = rng[31];
        if (cyc < hist_depth) begin
            hist[cyc] = adc_in;
        end
    end

    ////////////////////////////////
    // One table row
    ////////////////////////////////

    task automatic run_test(input int t);
        row_t        row;
        pulse_cfg_t  sel;
        int          period;
        int          open_edge;
        int          last_shot;
        int          close_edge;
        int          end_edge;
        int          e;
        int          shot;
        int          windows;
        laser_mask_t exp_wp;
        laser_mask_t exp_wn;
        logic        exp_trig;
        logic        exp_valid;
        logic        exp_rdy;
        cap_word_t   exp_word;
        row = tbl[t];
        sel = row.mode ? row.cap : row.com;
        period = int'(sel.period);
        test_errors = 0;
        windows = 0;
        cap_mode = row.mode;
        cap_cfg = row.cap;
        com_cfg = row.com;
        open_edge = cyc + 1;
        last_shot = open_edge + row.shots * period;
        // Early close lands while the last pulse and window are still running
        close_edge = row.early ? last_shot + 1 : last_shot + lanes * cap_words + 2;
        end_edge = close_edge + 2 * period + pulse_cycles;
        while (cyc <= end_edge) begin
            e = cyc;
            com_open = (e + 1 == open_edge);
            com_close = (e + 1 == close_edge);
            @(negedge clk200);
            exp_wp = '0;
            exp_trig = 1'b0;
            exp_valid = 1'b0;
            exp_rdy = 1'b0;
            exp_word = '0;
            for (int k = 1; k <= row.shots; k++) begin
                shot = open_edge + k * period;
                if (e == shot) begin
                    exp_trig = 1'b1;
                end
                if (e >= shot && e < shot + pulse_cycles) begin
                    exp_wp = sel.mask;
                end
                // First word one lane-fill plus one register after the shot
                for (int j = 0; j < cap_words; j++) begin
                    if (e == shot + lanes + 1 + lanes * j) begin
                        exp_valid = 1'b1;
                        exp_rdy = (j == cap_words - 1);
                        exp_word = expected_word(shot - 1 + lanes * j);
                    end
                end
            end
            exp_wn = ~exp_wp;
            check_eq("ldd_wp", exp_wp, ldd_wp);
            check_eq("ldd_wn", exp_wn, ldd_wn);
            check_eq("cap_trig", exp_trig, cap_trig);
            check_eq("cap_valid", exp_valid, cap_valid);
            check_eq("capr_rdy", exp_rdy, capr_rdy);
            if (exp_valid) begin
                check_eq("cap_data.data", exp_word.data, cap_data.data);
                check_eq("cap_data.ovf", exp_word.ovf, cap_data.ovf);
            end
            if (capr_rdy === 1'b1) begin
                windows++;
            end
            @(posedge clk200);
            #1;
        end
        assert (windows == row.shots) else begin
            $display("test %0d finished %0d capture windows but %0d shots were fired",
                     t, windows, row.shots);
            errors++;
            test_errors++;
        end
        $display("test %0d mode %0d mask %03b period %0d shots %0d early %0d: %0d errors",
                 t, row.mode, sel.mask, period, row.shots, row.early, test_errors);
    endtask

    initial begin : main
        arst_n = 1'b0;
        cap_mode = 1'b0;
        cap_cfg = '0;
        com_cfg = '0;
        com_open = 1'b0;
        com_close = 1'b0;
        adc_in = '0;
        repeat (reset_cycles) @(posedge clk200);
        #1;
        arst_n = 1'b1;
        @(negedge clk200);
        test_errors = 0;
        check_eq("ldd_wp", 3'b000, ldd_wp);
        check_eq("ldd_wn", 3'b111, ldd_wn);
        check_eq("cap_trig", 1'b0, cap_trig);
        check_eq("cap_valid", 1'b0, cap_valid);
        check_eq("capr_rdy", 1'b0, capr_rdy);
        $display("reset values: %0d errors", test_errors);
        @(posedge clk200);
        #1;
        for (int t = 0; t < n_rows; t++) begin
            run_test(t);
        end
        $display("%0d tests run, %0d errors", n_rows + 1, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Budget from the shots and periods of every row, plus slack
    initial begin : watchdog
        longint budget;
        budget = reset_cycles + 20;
        for (int t = 0; t < n_rows; t++) begin
            budget += (tbl[t].shots + 2) * (tbl[t].mode ? tbl[t].cap.period : tbl[t].com.period);
            budget += 60;
        end
        #(budget * 2 * clk_half);
        $display("Run stopped by watchdog after %0d cycles without finishing", budget);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: compile.f
design/laser_cfg_pkg.sv
design/adc_data_pkg.sv
design/laser_pulse_gen.sv
design/adc_sample_merge.sv
design/capture_ctrl.sv
design/lidar_top.sv
test/tb_lidar_top.sv
